/* Bender.yml */
package:
  name: mac_pause_rx

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mac_pause_pkg.sv
      - rtl/mcf_rx_parser.sv
      - rtl/pause_quanta_timer.sv
      - rtl/pause_status_collect.sv
      - rtl/mac_pause_rx.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/mac_pause_rx_checker.sv
      - verif/mac_pause_rx_tb.sv

/* mac_pause_rx.f */
+incdir+rtl
rtl/mac_pause_pkg.sv
rtl/mcf_rx_parser.sv
rtl/pause_quanta_timer.sv
rtl/pause_status_collect.sv
rtl/mac_pause_rx.sv
verif/mac_pause_rx_checker.sv
verif/mac_pause_rx_tb.sv

/* rtl/mac_pause_config.svh */
// MAC pause receive configuration
`ifndef MAC_PAUSE_CONFIG_SVH
`define MAC_PAUSE_CONFIG_SVH

// ============================================================
// datapath sizing.
// ============================================================

// receive word width from the XGMII decoder.
`define MAC_DATA_W 64
// priorities covered by PFC.
`define MAC_PRIO_N 8
`define MAC_QUANTA_W 16

// one quantum is 512 bit times, 8 cycles of a 64-bit word.
`define MAC_QUANTA_CYCLES 8
// holds 16'hffff * 8 without overflow.
`define MAC_TIMER_W 19

// shortest legal frame, 64 bytes.
`define MAC_MIN_WORDS 8

// ============================================================
// control frame match values.
// ============================================================

`define MAC_MCF_DST 48'h01_80_C2_00_00_01
`define MAC_MCF_ETH_TYPE 16'h8808
`define MAC_OPCODE_LFC 16'h0001
`define MAC_OPCODE_PFC 16'h0101

`endif

/* rtl/mac_pause_pkg.sv */
// MAC pause receive types
`include "mac_pause_config.svh"

package mac_pause_pkg;

// one beat of the receive stream.
typedef struct packed {
    logic                   valid;
    logic                   last;
    // decoder error flag for this beat.
    logic                   bad;
    logic [`MAC_DATA_W-1:0] data;
} rx_word_t;

// opcodes the parser acts on.
typedef enum logic [1:0] {
    opc_lfc,
    opc_pfc,
    opc_other
} mcf_opcode_e;

typedef enum logic [2:0] {
    st_idle,
    st_header,
    st_params,
    st_drain,
    st_drop
} parser_state_e;

// one flag per priority.
typedef logic [`MAC_PRIO_N-1:0] prio_vec_t;

// timer load request, one cycle wide.
typedef struct packed {
    logic                                      valid;
    prio_vec_t                                 load_mask;
    logic [`MAC_PRIO_N-1:0][`MAC_QUANTA_W-1:0] quanta;
} pause_cmd_t;

endpackage

/* rtl/mac_pause_rx.sv */
// MAC receive pause engine
`timescale 1ns/1ps

`include "mac_pause_config.svh"

module mac_pause_rx (
    input  wire logic                     rx_clk,
    input  wire logic                     rst,

    // receive stream from the XGMII decoder.
    input  wire mac_pause_pkg::rx_word_t  rx_word,

    // priority flow control.
    input  wire mac_pause_pkg::prio_vec_t rx_pfc_en,
    output wire mac_pause_pkg::prio_vec_t rx_pfc_req,
    output wire logic                     rx_pause_any,

    // status.
    output wire mac_pause_pkg::prio_vec_t stat_rx_pfc_xoff,
    output wire mac_pause_pkg::prio_vec_t stat_rx_pfc_xon,
    output wire logic                     stat_rx_mcf
);

mac_pause_pkg::pause_cmd_t pause_cmd;
mac_pause_pkg::prio_vec_t  timer_active;

mcf_rx_parser parser_inst (
    .rx_clk(rx_clk),
    .rst(rst),
    .rx_word(rx_word),
    .rx_pfc_en(rx_pfc_en),
    .pause_cmd(pause_cmd),
    .stat_rx_mcf(stat_rx_mcf)
);

// one timer per priority.
for (genvar i = 0; i < `MAC_PRIO_N; i++) begin : prio
    pause_quanta_timer timer_inst (
        .rx_clk(rx_clk),
        .rst(rst),
        .load(pause_cmd.valid && pause_cmd.load_mask[i]),
        .quanta(pause_cmd.quanta[i]),
        .active(timer_active[i])
    );
end

pause_status_collect collect_inst (
    .rx_clk(rx_clk),
    .rst(rst),
    .timer_active(timer_active),
    .rx_pfc_req(rx_pfc_req),
    .rx_pause_any(rx_pause_any),
    .stat_rx_pfc_xoff(stat_rx_pfc_xoff),
    .stat_rx_pfc_xon(stat_rx_pfc_xon)
);

endmodule

/* rtl/mcf_rx_parser.sv */
// MAC control frame parser
`timescale 1ns/1ps

`include "mac_pause_config.svh"

module mcf_rx_parser (
    input  wire logic                     rx_clk,
    input  wire logic                     rst,
    input  wire mac_pause_pkg::rx_word_t  rx_word,
    input  wire mac_pause_pkg::prio_vec_t rx_pfc_en,
    output mac_pause_pkg::pause_cmd_t     pause_cmd,
    output logic                          stat_rx_mcf
);

localparam int cnt_w = $clog2(`MAC_MIN_WORDS) + 1;
// word counter saturates here, long frames only need to pass the length check.
localparam logic [cnt_w-1:0] cnt_max = cnt_w'(`MAC_MIN_WORDS);
localparam logic [cnt_w-1:0] last_min = cnt_w'(`MAC_MIN_WORDS - 1);
// words holding the pause parameters.
localparam logic [cnt_w-1:0] w_cls = cnt_w'(2);
localparam logic [cnt_w-1:0] w_q3 = cnt_w'(3);
localparam logic [cnt_w-1:0] w_q7 = cnt_w'(4);

mac_pause_pkg::parser_state_e state;
mac_pause_pkg::mcf_opcode_e   opc_word;
mac_pause_pkg::mcf_opcode_e   opc_q;

logic [cnt_w-1:0]                          word_cnt;
logic                                      bad_seen;
logic                                      bad_any;
logic                                      dst_ok;
logic                                      hdr_ok;
logic                                      accept;
logic                                      mcf_hold;
// class vector for PFC, the single quanta for LFC.
logic [`MAC_QUANTA_W-1:0]                  param0;
logic [`MAC_PRIO_N-1:0][`MAC_QUANTA_W-1:0] quanta_q;

always_comb begin
    case (rx_word.data[15:0])
        `MAC_OPCODE_LFC: opc_word = mac_pause_pkg::opc_lfc;
        `MAC_OPCODE_PFC: opc_word = mac_pause_pkg::opc_pfc;
        default:         opc_word = mac_pause_pkg::opc_other;
    endcase
end

assign dst_ok = rx_word.data[63:16] == `MAC_MCF_DST;
assign hdr_ok = (rx_word.data[31:16] == `MAC_MCF_ETH_TYPE) &&
                (opc_word != mac_pause_pkg::opc_other);
assign bad_any = bad_seen || rx_word.bad;

// only a clean, full length control frame ends in drain.
assign accept = (state == mac_pause_pkg::st_drain) && rx_word.valid && rx_word.last &&
                !bad_any && (word_cnt >= last_min);

// ============================================================
// frame walk.
// ============================================================

always_ff @(posedge rx_clk) begin
    if (rx_word.valid) begin
        if (rx_word.last) begin
            word_cnt <= '0;
        end else if (word_cnt != cnt_max) begin
            word_cnt <= word_cnt + 1'b1;
        end
        bad_seen <= rx_word.last ? 1'b0 : bad_any;

        case (state)
            mac_pause_pkg::st_idle: begin
                if (!rx_word.last) begin
                    state <= dst_ok ? mac_pause_pkg::st_header : mac_pause_pkg::st_drop;
                end
            end
            mac_pause_pkg::st_header: begin
                if (rx_word.last) begin
                    state <= mac_pause_pkg::st_idle;
                end else begin
                    state <= hdr_ok ? mac_pause_pkg::st_params : mac_pause_pkg::st_drop;
                end
            end
            mac_pause_pkg::st_params: begin
                if (rx_word.last) begin
                    state <= mac_pause_pkg::st_idle;
                end else if (word_cnt == w_q7) begin
                    state <= mac_pause_pkg::st_drain;
                end
            end
            default: begin
                // drain and drop both wait for the end of frame.
                if (rx_word.last) begin
                    state <= mac_pause_pkg::st_idle;
                end
            end
        endcase
    end

    if (rst) begin
        state <= mac_pause_pkg::st_idle;
        word_cnt <= '0;
        bad_seen <= 1'b0;
    end
end

// header and parameter capture.
always_ff @(posedge rx_clk) begin
    if (rx_word.valid && state == mac_pause_pkg::st_header) begin
        opc_q <= opc_word;
    end
    if (rx_word.valid && state == mac_pause_pkg::st_params) begin
        if (word_cnt == w_cls) begin
            param0 <= rx_word.data[63:48];
            quanta_q[0] <= rx_word.data[47:32];
            quanta_q[1] <= rx_word.data[31:16];
            quanta_q[2] <= rx_word.data[15:0];
        end else if (word_cnt == w_q3) begin
            quanta_q[3] <= rx_word.data[63:48];
            quanta_q[4] <= rx_word.data[47:32];
            quanta_q[5] <= rx_word.data[31:16];
            quanta_q[6] <= rx_word.data[15:0];
        end else if (word_cnt == w_q7) begin
            quanta_q[7] <= rx_word.data[63:48];
        end
    end
end

// ============================================================
// command and frame count.
// ============================================================

always_ff @(posedge rx_clk) begin
    pause_cmd.valid <= accept;
    if (opc_q == mac_pause_pkg::opc_lfc) begin
        // LFC pauses every enabled priority for the same time.
        pause_cmd.load_mask <= rx_pfc_en;
        pause_cmd.quanta <= {`MAC_PRIO_N{param0}};
    end else begin
        pause_cmd.load_mask <= rx_pfc_en & param0[`MAC_PRIO_N-1:0];
        pause_cmd.quanta <= quanta_q;
    end

    // delayed to line up with the collector outputs.
    mcf_hold <= pause_cmd.valid;
    stat_rx_mcf <= mcf_hold;

    if (rst) begin
        pause_cmd.valid <= 1'b0;
        mcf_hold <= 1'b0;
        stat_rx_mcf <= 1'b0;
    end
end

cmd_single_pulse: assert property (@(posedge rx_clk) disable iff (rst)
    pause_cmd.valid |=> !pause_cmd.valid)
    else $error("pause command valid held for two cycles");

endmodule

/* rtl/pause_quanta_timer.sv */
// Pause quanta countdown timer
`timescale 1ns/1ps

`include "mac_pause_config.svh"

module pause_quanta_timer (
    input  wire logic                     rx_clk,
    input  wire logic                     rst,
    input  wire logic                     load,
    input  wire logic [`MAC_QUANTA_W-1:0] quanta,
    output logic                          active
);

// sized to the counter so the product keeps all its bits.
localparam logic [`MAC_TIMER_W-1:0] quanta_cycles = `MAC_QUANTA_CYCLES;

// cycles left in the current pause.
logic [`MAC_TIMER_W-1:0] count;

// ============================================================
// countdown.
// ============================================================

always_ff @(posedge rx_clk) begin
    if (rst) begin
        count <= '0;
    end else if (load) begin
        // a new frame restarts the count, zero quanta ends the pause.
        count <= quanta * quanta_cycles;
    end else if (count != '0) begin
        count <= count - 1'b1;
    end
end

assign active = count != '0;

count_no_wrap: assert property (@(posedge rx_clk) disable iff (rst)
    (!load && count == '0) |=> count == '0)
    else $error("pause counter wrapped below zero");

endmodule

/* rtl/pause_status_collect.sv */
// Pause status collector
`timescale 1ns/1ps

module pause_status_collect (
    input  wire logic                     rx_clk,
    input  wire logic                     rst,
    input  wire mac_pause_pkg::prio_vec_t timer_active,
    output mac_pause_pkg::prio_vec_t      rx_pfc_req,
    output logic                          rx_pause_any,
    output mac_pause_pkg::prio_vec_t      stat_rx_pfc_xoff,
    output mac_pause_pkg::prio_vec_t      stat_rx_pfc_xon
);

// ============================================================
// request register and edge detect.
// ============================================================

always_ff @(posedge rx_clk) begin
    if (rst) begin
        rx_pfc_req <= '0;
        rx_pause_any <= 1'b0;
        stat_rx_pfc_xoff <= '0;
        stat_rx_pfc_xon <= '0;
    end else begin
        rx_pfc_req <= timer_active;
        // same as the OR of the registered requests.
        rx_pause_any <= |timer_active;

        // rx_pfc_req still holds the last cycle's state here.
        stat_rx_pfc_xoff <= timer_active & ~rx_pfc_req;
        stat_rx_pfc_xon <= ~timer_active & rx_pfc_req;
    end
end

xon_xoff_exclusive: assert property (@(posedge rx_clk) disable iff (rst)
    (stat_rx_pfc_xon & stat_rx_pfc_xoff) == '0)
    else $error("xon and xoff together on priorities %h",
        stat_rx_pfc_xon & stat_rx_pfc_xoff);

endmodule

/* verif/mac_pause_rx_checker.sv */
// Pause engine checker
`timescale 1ns/1ps

`include "mac_pause_config.svh"

module mac_pause_rx_checker (
    input  wire logic                     rx_clk,
    input  wire logic                     rst,
    input  wire mac_pause_pkg::rx_word_t  rx_word,
    input  wire mac_pause_pkg::prio_vec_t rx_pfc_en,
    input  wire mac_pause_pkg::prio_vec_t rx_pfc_req,
    input  wire logic                     rx_pause_any,
    input  wire mac_pause_pkg::prio_vec_t stat_rx_pfc_xoff,
    input  wire mac_pause_pkg::prio_vec_t stat_rx_pfc_xon,
    input  wire logic                     stat_rx_mcf,
    output int                            errors,
    output int                            checks,
    output int                            accepted
);

logic [`MAC_DATA_W-1:0]    frame_q[$];
logic                      frame_bad;
logic                      started;
// accepted frames travel two stages before they reach the outputs.
mac_pause_pkg::pause_cmd_t stage1;
mac_pause_pkg::pause_cmd_t stage2;
int                        remain[`MAC_PRIO_N];
mac_pause_pkg::prio_vec_t  exp_req;
mac_pause_pkg::prio_vec_t  exp_xoff;
mac_pause_pkg::prio_vec_t  exp_xon;
logic                      exp_mcf;

initial begin
    errors = 0;
    checks = 0;
    accepted = 0;
    started = 1'b0;
end

// ============================================================
// frame rules.
// ============================================================

function automatic mac_pause_pkg::pause_cmd_t decode_frame(input mac_pause_pkg::prio_vec_t en);
    mac_pause_pkg::pause_cmd_t cmd;
    cmd = '0;
    if (frame_q.size() >= `MAC_MIN_WORDS && !frame_bad &&
        frame_q[0][63:16] == `MAC_MCF_DST && frame_q[1][31:16] == `MAC_MCF_ETH_TYPE) begin
        if (frame_q[1][15:0] == `MAC_OPCODE_LFC) begin
            cmd.valid = 1'b1;
            cmd.load_mask = en;
            for (int i = 0; i < `MAC_PRIO_N; i++) begin
                cmd.quanta[i] = frame_q[2][63:48];
            end
        end else if (frame_q[1][15:0] == `MAC_OPCODE_PFC) begin
            cmd.valid = 1'b1;
            cmd.load_mask = en & frame_q[2][55:48];
            // quanta fill each word from the top down.
            cmd.quanta[0] = frame_q[2][47:32];
            cmd.quanta[1] = frame_q[2][31:16];
            cmd.quanta[2] = frame_q[2][15:0];
            cmd.quanta[3] = frame_q[3][63:48];
            cmd.quanta[4] = frame_q[3][47:32];
            cmd.quanta[5] = frame_q[3][31:16];
            cmd.quanta[6] = frame_q[3][15:0];
            cmd.quanta[7] = frame_q[4][63:48];
        end
    end
    return cmd;
endfunction

task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("FAIL %s got %h expected %h at %0t ns", name, got, want, $time);
    end
endtask

// ============================================================
// reference model, one step per clock.
// ============================================================

always @(posedge rx_clk) begin : model
    mac_pause_pkg::pause_cmd_t apply;
    mac_pause_pkg::prio_vec_t  prev;
    started = 1'b1;
    apply = stage2;
    stage2 = stage1;
    stage1 = '0;
    if (rx_word.valid && !rst) begin
        frame_q.push_back(rx_word.data);
        frame_bad = frame_bad | rx_word.bad;
        if (rx_word.last) begin
            stage1 = decode_frame(rx_pfc_en);
            frame_q.delete();
            frame_bad = 1'b0;
        end
    end
    prev = exp_req;
    for (int i = 0; i < `MAC_PRIO_N; i++) begin
        if (apply.valid && apply.load_mask[i]) begin
            remain[i] = apply.quanta[i] * `MAC_QUANTA_CYCLES;
        end else if (remain[i] > 0) begin
            remain[i]--;
        end
        exp_req[i] = remain[i] != 0;
    end
    exp_xoff = exp_req & ~prev;
    exp_xon = ~exp_req & prev;
    exp_mcf = apply.valid;
    if (apply.valid) begin
        accepted++;
    end
    if (rst) begin
        stage1 = '0;
        stage2 = '0;
        frame_q.delete();
        frame_bad = 1'b0;
        remain = '{default: 0};
        exp_req = '0;
        exp_xoff = '0;
        exp_xon = '0;
        exp_mcf = 1'b0;
    end
end

// outputs are compared mid cycle.
always @(negedge rx_clk) begin
    if (started) begin
        check_val("rx_pfc_req", rx_pfc_req, exp_req);
        check_val("rx_pause_any", rx_pause_any, |exp_req);
        check_val("stat_rx_pfc_xoff", stat_rx_pfc_xoff, exp_xoff);
        check_val("stat_rx_pfc_xon", stat_rx_pfc_xon, exp_xon);
        check_val("stat_rx_mcf", stat_rx_mcf, exp_mcf);
    end
end

endmodule

/* verif/mac_pause_rx_tb.sv */
// Pause engine testbench
`timescale 1ns/1ps

`include "mac_pause_config.svh"

module mac_pause_rx_tb;

localparam int drain_limit = 3000;

logic                     rx_clk = 1'b0;
logic                     rst;
mac_pause_pkg::rx_word_t  rx_word;
mac_pause_pkg::prio_vec_t rx_pfc_en;
mac_pause_pkg::prio_vec_t rx_pfc_req;
mac_pause_pkg::prio_vec_t stat_rx_pfc_xoff;
mac_pause_pkg::prio_vec_t stat_rx_pfc_xon;
logic                     rx_pause_any;
logic                     stat_rx_mcf;
int                       errors;
int                       checks;
int                       accepted;
int                       tests = 0;
logic                     timed_out = 1'b0;
integer                   seed;

always #2 rx_clk = ~rx_clk;

mac_pause_rx uut (.*);

mac_pause_rx_checker check_inst (.*);

task automatic drive_beat(input logic valid, input logic last, input logic bad,
                          input logic [`MAC_DATA_W-1:0] data);
    @(posedge rx_clk);
    #1;
    rx_word = {valid, last, bad, data};
endtask

// small values dominate so that pauses overlap the following frames.
function automatic logic [`MAC_QUANTA_W-1:0] rand_quanta();
    int sel;
    sel = $unsigned($random(seed)) % 8;
    if (sel == 0) begin
        return '0;
    end else if (sel < 6) begin
        return 16'(1 + $unsigned($random(seed)) % 7);
    end else if (sel == 6) begin
        return 16'(8 + $unsigned($random(seed)) % 56);
    end else begin
        return 16'(64 + $unsigned($random(seed)) % 192);
    end
endfunction

// ============================================================
// frame builder, kind 0 LFC, 1 PFC, 2 corrupted.
// ============================================================

task automatic send_frame(input int kind);
    logic [`MAC_DATA_W-1:0] w[10];
    int base;
    int flaw;
    int len;
    int bad_at;
    base = (kind == 2) ? $unsigned($random(seed)) % 2 : kind;
    flaw = (kind == 2) ? $unsigned($random(seed)) % 5 : 5;
    len = `MAC_MIN_WORDS + $unsigned($random(seed)) % 3;
    bad_at = -1;
    for (int i = 0; i < 10; i++) begin
        w[i] = {$random(seed), $random(seed)};
    end
    w[0][63:16] = `MAC_MCF_DST;
    w[1][31:16] = `MAC_MCF_ETH_TYPE;
    if (base == 0) begin
        w[1][15:0] = `MAC_OPCODE_LFC;
        w[2][63:48] = rand_quanta();
    end else begin
        w[1][15:0] = `MAC_OPCODE_PFC;
        w[2] = {8'h00, 8'($random(seed)), rand_quanta(), rand_quanta(), rand_quanta()};
        w[3] = {rand_quanta(), rand_quanta(), rand_quanta(), rand_quanta()};
        w[4][63:48] = rand_quanta();
    end
    case (flaw)
        0: w[0][63:16] = w[0][63:16] ^ (48'h1 << ($unsigned($random(seed)) % 48));
        1: w[1][31:16] = w[1][31:16] ^ (16'h1 << ($unsigned($random(seed)) % 16));
        // a low bit flip never turns one valid opcode into the other.
        2: w[1][15:0] = w[1][15:0] ^ (16'h1 << ($unsigned($random(seed)) % 8));
        3: bad_at = $unsigned($random(seed)) % len;
        4: len = 1 + $unsigned($random(seed)) % (`MAC_MIN_WORDS - 1);
        default: ;
    endcase
    for (int i = 0; i < len; i++) begin
        drive_beat(1'b1, i == len - 1, i == bad_at, w[i]);
    end
endtask

// mode 3 mixes all frame kinds.
task automatic run_phase(input string name, input int frames, input int mode,
                         input int max_gap);
    int errs_before;
    int quiet;
    int gap;
    errs_before = errors;
    for (int i = 0; i < frames; i++) begin
        gap = $unsigned($random(seed)) % (max_gap + 1);
        for (int j = 0; j < gap; j++) begin
            drive_beat(1'b0, 1'b0, 1'b0, '0);
            if (j == 0 && $unsigned($random(seed)) % 4 == 0) begin
                rx_pfc_en = 8'($random(seed));
            end
        end
        send_frame(mode == 3 ? $unsigned($random(seed)) % 3 : mode);
    end
    quiet = 0;
    for (int n = 0; n < drain_limit && quiet < 4; n++) begin
        drive_beat(1'b0, 1'b0, 1'b0, '0);
        if (rx_pause_any === 1'b0 && stat_rx_mcf === 1'b0 && stat_rx_pfc_xon === '0) begin
            quiet++;
        end else begin
            quiet = 0;
        end
    end
    if (quiet < 4) begin
        $display("timeout: pause requests in %s did not clear within %0d cycles",
                 name, drain_limit);
        timed_out = 1'b1;
    end
    tests++;
    $display("test %s finished with %0d errors", name, errors - errs_before);
endtask

initial begin
    seed = 32'hb798_a3f2;
    rst = 1'b1;
    rx_word = '0;
    rx_pfc_en = 8'($random(seed));
    repeat (16) @(posedge rx_clk);
    #1;
    rst = 1'b0;
    run_phase("after_reset", 0, 0, 0);
    run_phase("pfc_frames", 40, 1, 8);
    run_phase("lfc_frames", 30, 0, 8);
    run_phase("corrupt_frames", 40, 2, 4);
    run_phase("mixed_traffic", 150, 3, 2);
    if (accepted == 0) begin
        $display("no control frame was accepted during the run");
    end
    $display("%0d tests, %0d checks, %0d errors, %0d frames accepted",
             tests, checks, errors, accepted);
    if (timed_out || errors != 0 || accepted == 0) begin
        $display("Checks failed");
    end else begin
        $display("All checks passed");
    end
    $finish;
end

endmodule
